/* files.f */
+incdir+verification
hdl/clmul_pkg.sv
hdl/operand_bank.sv
hdl/limb_clmul.sv
hdl/mul_sequencer.sv
hdl/column_accumulator.sv
hdl/poly_mul_284.sv
verification/tb_poly_mul.sv

/* Bender.yml */
package:
  name: poly_mul_284

sources:
  - files:
      - hdl/clmul_pkg.sv
      - hdl/operand_bank.sv
      - hdl/limb_clmul.sv
      - hdl/mul_sequencer.sv
      - hdl/column_accumulator.sv
      - hdl/poly_mul_284.sv

  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_poly_mul.sv

/* verification/tb_clmul_model.svh */
`ifndef TB_CLMUL_MODEL_SVH
`define TB_CLMUL_MODEL_SVH

// golden carry-less product, one coefficient pair at a time
function automatic prod_t clmul_ref(input poly_t a, input poly_t b);
    prod_t r;
    r = '0;
    for (int i = 0; i < POLY_W; i++) begin
        for (int j = 0; j < POLY_W; j++) begin
            // coefficients add mod 2
            r[i + j] = r[i + j] ^ (a[i] & b[j]);
        end
    end
    return r;
endfunction

// x or z on the DUT side counts as a mismatch
task automatic check_value(
    input string name,
    input prod_t got,
    input prod_t expected
);
    check_count++;
    if (got !== expected) begin
        error_count++;
        $display("FAIL at %0t: %s got %0h expected %0h", $time, name, got, expected);
    end
endtask

`endif

/* verification/tb_poly_mul.sv */
`timescale 1ns/1ps

module tb_poly_mul;
    import clmul_pkg::*;

    localparam int NUM_ENTRIES  = 10;
    localparam int RESET_CYCLES = 16;
    localparam int LATENCY      = 19;
    localparam int MAX_CYCLES   = 16 + 30 * NUM_ENTRIES + 50;

    // cycle of the ignored start, counted from the accepted one
    localparam int BUSY_START_CYCLE = 5;

    logic  clk;
    logic  reset;
    logic  start;
    poly_t u;
    poly_t v;
    prod_t w;
    logic  done;

    int     error_count;
    int     check_count;
    int     cycle_count;
    integer seed;

    poly_t tab_u    [NUM_ENTRIES];
    poly_t tab_v    [NUM_ENTRIES];
    bit    tab_busy [NUM_ENTRIES];

    `include "tb_clmul_model.svh"

    poly_mul_284 dut (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .u     (u),
        .v     (v),
        .w     (w),
        .done  (done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    function automatic poly_t random_poly();
        poly_t r;
        r = '0;
        // nine words cover all 284 bits
        for (int k = 0; k < 9; k++) begin
            r = (r << 32) | poly_t'($unsigned($random(seed)));
        end
        return r;
    endfunction

    task automatic build_table();
        limb_t l_a;
        limb_t l_b;
        l_a = limb_t'(random_poly());
        l_b = limb_t'(random_poly());
        // zero
        tab_u[0]    = '0;
        tab_v[0]    = '1;
        tab_busy[0] = 1'b0;
        // one
        tab_u[1]    = poly_t'(1);
        tab_v[1]    = random_poly();
        tab_busy[1] = 1'b0;
        // x^283 squared gives the top product bit
        tab_u[2]    = poly_t'(1) << (POLY_W - 1);
        tab_v[2]    = poly_t'(1) << (POLY_W - 1);
        tab_busy[2] = 1'b0;
        tab_u[3]    = '1;
        tab_v[3]    = '1;
        tab_busy[3] = 1'b1;
        // one limb each, landing in column 3
        tab_u[4]    = poly_t'(l_a) << (2 * LIMB_W);
        tab_v[4]    = poly_t'(l_b) << LIMB_W;
        tab_busy[4] = 1'b0;
        for (int i = 5; i < NUM_ENTRIES; i++) begin
            tab_u[i]    = random_poly();
            tab_v[i]    = random_poly();
            tab_busy[i] = (i % 2 == 0);
        end
        tab_v[7] = '1;
    endtask

    task automatic run_entry(input int idx);
        prod_t expected;
        int    cyc;
        bit    seen;
        expected = clmul_ref(tab_u[idx], tab_v[idx]);
        @(posedge clk);
        start <= 1'b1;
        u     <= tab_u[idx];
        v     <= tab_v[idx];
        @(negedge clk);
        // previous result still held while the new start is pending
        check_value("done_before_start", done, (idx != 0));
        @(posedge clk);
        start <= 1'b0;
        // operands are latched now
        u     <= random_poly();
        v     <= random_poly();
        @(negedge clk);
        cyc = 1;
        check_value("done_after_start", done, 1'b0);
        seen = 1'b0;
        while (!seen && cyc < LATENCY + 10) begin
            @(posedge clk);
            if (tab_busy[idx] && (cyc + 1 == BUSY_START_CYCLE)) begin
                start <= 1'b1;
                u     <= random_poly();
                v     <= random_poly();
            end else begin
                start <= 1'b0;
            end
            cyc++;
            @(negedge clk);
            if (done === 1'b1) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            error_count++;
            $display("ERROR at %0t: done never went high for entry %0d", $time, idx);
        end else begin
            check_value("done_latency", cyc, LATENCY);
            check_value("w", w, expected);
        end
    endtask

    initial begin
        reset       = 1'b1;
        start       = 1'b0;
        u           = '0;
        v           = '0;
        error_count = 0;
        check_count = 0;
        seed        = 32'ha8ddbc36;
        build_table();

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("done_reset", done, 1'b0);
        check_value("w_reset", w, '0);

        // entries run back to back, each start lands while done is high
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            run_entry(i);
        end

        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* hdl/poly_mul_284.sv */
`timescale 1ns/1ps

module poly_mul_284 (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  clmul_pkg::poly_t u,
    input  clmul_pkg::poly_t v,
    output clmul_pkg::prod_t w,
    output logic             done
);
    import clmul_pkg::*;

    logic        load;
    logic        clear;
    limb_idx_t   a_idx;
    limb_idx_t   b_idx;
    limb_pair_t  pair;
    issue_beat_t issue;
    prod_beat_t  beat;

    mul_sequencer u_seq (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .load  (load),
        .clear (clear),
        .a_idx (a_idx),
        .b_idx (b_idx),
        .issue (issue)
    );

    operand_bank u_bank (
        .clk   (clk),
        .reset (reset),
        .load  (load),
        .u     (u),
        .v     (v),
        .a_idx (a_idx),
        .b_idx (b_idx),
        .pair  (pair)
    );

    // single shared limb multiplier
    limb_clmul u_mul (
        .clk   (clk),
        .reset (reset),
        .pair  (pair),
        .issue (issue),
        .beat  (beat)
    );

    column_accumulator u_acc (
        .clk   (clk),
        .reset (reset),
        .clear (clear),
        .beat  (beat),
        .w     (w),
        .done  (done)
    );

endmodule

/* hdl/column_accumulator.sv */
`timescale 1ns/1ps

module column_accumulator (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clear,
    input  clmul_pkg::prod_beat_t beat,
    output clmul_pkg::prod_t      w,
    output logic                  done
);
    import clmul_pkg::*;

    prod_beat_t                  beat_q;
    limb_prod_t [NUM_COLS-1:0]   cols;
    limb_prod_t [NUM_COLS-1:0]   cols_next;
    prod_t                       w_next;

    // input stage, one beat held while the columns update
    always_ff @(posedge clk) begin
        beat_q.last <= beat.last;
        beat_q.col  <= beat.col;
        beat_q.prod <= beat.prod;
        if (reset) begin
            beat_q.valid <= 1'b0;
        end else begin
            beat_q.valid <= beat.valid;
        end
    end

    always_comb begin
        cols_next = cols;
        if (beat_q.valid) begin
            cols_next[beat_q.col] = cols[beat_q.col] ^ beat_q.prod;
        end
    end

    // column k lands at bit 71*k, overlaps fold by xor
    always_comb begin
        w_next = '0;
        for (int k = 0; k < NUM_COLS; k++) begin
            w_next = w_next ^ (prod_t'(cols_next[k]) << (LIMB_W * k));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            w    <= '0;
            done <= 1'b0;
        end else if (clear) begin
            cols <= '0;
            done <= 1'b0;
        end else if (beat_q.valid) begin
            cols <= cols_next;
            // last beat goes straight into the result
            if (beat_q.last) begin
                w    <= w_next;
                done <= 1'b1;
            end
        end
    end

endmodule

/* hdl/mul_sequencer.sv */
`timescale 1ns/1ps

module mul_sequencer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    output logic                   load,
    output logic                   clear,
    output clmul_pkg::limb_idx_t   a_idx,
    output clmul_pkg::limb_idx_t   b_idx,
    output clmul_pkg::issue_beat_t issue
);
    import clmul_pkg::*;

    seq_state_t state;
    beat_cnt_t  cnt;
    logic       accept;
    logic       last_beat;
    logic       drain_end;

    // start is only looked at while idle
    assign accept = (state == IDLE) && start;
    assign load   = accept;
    assign clear  = accept;

    // upper counter bits pick the U limb, lower ones the V limb
    assign a_idx = cnt[3:2];
    assign b_idx = cnt[1:0];

    assign last_beat = (cnt == beat_cnt_t'(NUM_BEATS - 1));
    assign drain_end = (cnt == beat_cnt_t'(DRAIN_CYCLES - 1));

    always_comb begin
        issue.valid = (state == ISSUE);
        issue.last  = (state == ISSUE) && last_beat;
        issue.col   = col_idx_t'(a_idx) + col_idx_t'(b_idx);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= ISSUE;
                        cnt   <= '0;
                    end
                end
                ISSUE: begin
                    // counter wraps to zero on the way into drain
                    cnt <= cnt + 1'b1;
                    if (last_beat) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    // multiplier and accumulator input stage empty out
                    if (drain_end) begin
                        state <= IDLE;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                    cnt   <= '0;
                end
            endcase
        end
    end

endmodule

/* hdl/limb_clmul.sv */
`timescale 1ns/1ps

module limb_clmul (
    input  logic                   clk,
    input  logic                   reset,
    input  clmul_pkg::limb_pair_t  pair,
    input  clmul_pkg::issue_beat_t issue,
    output clmul_pkg::prod_beat_t  beat
);
    import clmul_pkg::*;

    limb_prod_t prod_c;

    // shift-and-xor, no carries between bit positions
    always_comb begin
        prod_c = '0;
        for (int i = 0; i < LIMB_W; i++) begin
            if (pair.b[i]) begin
                prod_c = prod_c ^ (limb_prod_t'(pair.a) << i);
            end
        end
    end

    // tag rides along unchanged
    always_ff @(posedge clk) begin
        beat.last <= issue.last;
        beat.col  <= issue.col;
        beat.prod <= prod_c;
        if (reset) begin
            beat.valid <= 1'b0;
        end else begin
            beat.valid <= issue.valid;
        end
    end

endmodule

/* hdl/operand_bank.sv */
`timescale 1ns/1ps

module operand_bank (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  load,
    input  clmul_pkg::poly_t      u,
    input  clmul_pkg::poly_t      v,
    input  clmul_pkg::limb_idx_t  a_idx,
    input  clmul_pkg::limb_idx_t  b_idx,
    output clmul_pkg::limb_pair_t pair
);
    import clmul_pkg::*;

    // limb 0 sits in the low bits of each operand
    limb_t [NUM_LIMBS-1:0] u_q;
    limb_t [NUM_LIMBS-1:0] v_q;

    // held for the whole multiply, inputs may move after start
    always_ff @(posedge clk) begin
        if (reset) begin
            u_q <= '0;
            v_q <= '0;
        end else if (load) begin
            u_q <= u;
            v_q <= v;
        end
    end

    always_comb begin
        pair.a = u_q[a_idx];
        pair.b = v_q[b_idx];
    end

endmodule

/* hdl/clmul_pkg.sv */
package clmul_pkg;

    // operand split
    localparam int LIMB_W    = 71;
    localparam int NUM_LIMBS = 4;
    localparam int POLY_W    = LIMB_W * NUM_LIMBS;

    // schoolbook columns, limb index sums 0..6
    localparam int NUM_COLS  = 2 * NUM_LIMBS - 1;

    localparam int LIMB_PROD_W = 2 * LIMB_W - 1;
    localparam int PROD_W      = 2 * POLY_W - 1;

    // one limb product per index pair
    localparam int NUM_BEATS    = NUM_LIMBS * NUM_LIMBS;
    localparam int DRAIN_CYCLES = 2;

    typedef logic [LIMB_W-1:0]      limb_t;
    typedef logic [POLY_W-1:0]      poly_t;
    typedef logic [LIMB_PROD_W-1:0] limb_prod_t;
    typedef logic [PROD_W-1:0]      prod_t;

    typedef logic [1:0] limb_idx_t;
    typedef logic [2:0] col_idx_t;
    typedef logic [$clog2(NUM_BEATS)-1:0] beat_cnt_t;

    typedef struct packed {
        limb_t a;
        limb_t b;
    } limb_pair_t;

    // tag travelling with each limb pair
    typedef struct packed {
        logic     valid;
        logic     last;
        col_idx_t col;
    } issue_beat_t;

    typedef struct packed {
        logic       valid;
        logic       last;
        col_idx_t   col;
        limb_prod_t prod;
    } prod_beat_t;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        DRAIN
    } seq_state_t;

endpackage
